//--- list.f
+incdir+logic
logic/amo_pkg.sv
logic/amo_alu.sv
logic/amo_engine.sv
logic/mem_arbiter.sv
logic/amo_req_steer.sv
logic/amo_adapter_top.sv
tests/tb_memory.sv
tests/amo_checker.sv
tests/amo_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the AMO adapter testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module amo_tb -f list.f \
    && ./obj_dir/Vamo_tb +verilator+error+limit+1000 | tee /dev/stderr \
        | grep -Fx "Simulation finished: PASS" > /dev/null \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }

//--- tests/amo_tb.sv
//****************************************************************************
// AMO adapter testbench
// Directed and random requests checked against a memory and ALU model
//****************************************************************************

`timescale 1ns/100ps

`include "amo_settings.svh"

module amo_tb;

    typedef logic [`AMO_ADDR_W-1:0] addr_t;

    localparam int TIMEOUT = 200;

    logic              clk;
    logic              rst_n;
    logic              cli_req_valid;
    logic              cli_req_ready;
    amo_pkg::cli_req_t cli_req;
    logic              cli_rsp_valid;
    logic              cli_rsp_ready;
    amo_pkg::cli_rsp_t cli_rsp;
    logic              mem_req_valid;
    logic              mem_req_ready;
    amo_pkg::mem_req_t mem_req;
    logic              mem_rsp_valid;
    amo_pkg::data_t    mem_rsp_rdata;

    // Expected memory contents
    amo_pkg::data_t    model_mem [`AMO_MEM_WORDS];
    int                chk_cnt;
    int                err_cnt;
    int unsigned       prot_cnt;
    bit                stop_run;

    amo_adapter_top amo_adapter_top_i (
        .clk_i           (clk),
        .rst_ni          (rst_n),
        .cli_req_valid_i (cli_req_valid),
        .cli_req_ready_o (cli_req_ready),
        .cli_req_i       (cli_req),
        .cli_rsp_valid_o (cli_rsp_valid),
        .cli_rsp_ready_i (cli_rsp_ready),
        .cli_rsp_o       (cli_rsp),
        .mem_req_valid_o (mem_req_valid),
        .mem_req_ready_i (mem_req_ready),
        .mem_req_o       (mem_req),
        .mem_rsp_valid_i (mem_rsp_valid),
        .mem_rsp_rdata_i (mem_rsp_rdata)
    );

    tb_memory tb_memory_i (
        .clk_i           (clk),
        .rst_ni          (rst_n),
        .mem_req_valid_i (mem_req_valid),
        .mem_req_ready_o (mem_req_ready),
        .mem_req_i       (mem_req),
        .mem_rsp_valid_o (mem_rsp_valid),
        .mem_rsp_rdata_o (mem_rsp_rdata)
    );

    always #50 clk = ~clk;

    function automatic amo_pkg::data_t fill_word(input int unsigned addr);
        return 32'h9e37_79b9 * (addr + 1);
    endfunction

    // New word of an atomic, fn counts in opcode pair order
    function automatic amo_pkg::data_t alu_model(input int fn, input amo_pkg::data_t old,
                                                 input amo_pkg::data_t opd);
        case (fn)
            0:       return opd;
            1:       return old + opd;
            2:       return old & ~opd;
            3:       return old | opd;
            4:       return old ^ opd;
            5:       return ($signed(old) > $signed(opd)) ? old : opd;
            6:       return ($signed(old) < $signed(opd)) ? old : opd;
            7:       return (old > opd) ? old : opd;
            8:       return (old < opd) ? old : opd;
            default: return old;
        endcase
    endfunction

    function automatic amo_pkg::amo_op_e atomic_op(input int fn, input bit store);
        return amo_pkg::amo_op_e'(5'(int'(amo_pkg::OP_ALD_SWAP) + 2 * fn + int'(store)));
    endfunction

    task automatic note_timeout(input string what);
        err_cnt++;
        stop_run = 1'b1;
        $display("Timeout: %s", what);
    endtask

    task automatic check_word(input string name, input amo_pkg::data_t exp,
                              input amo_pkg::data_t act);
        if (stop_run) return;
        chk_cnt++;
        assert (act === exp) else begin
            err_cnt++;
            $display("** Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // One full request, response held back for hold cycles
    task automatic send_request(input amo_pkg::amo_op_e op, input addr_t addr,
                                input amo_pkg::data_t wdata, input int unsigned hold,
                                output amo_pkg::cli_rsp_t rsp);
        int                waited;
        amo_pkg::cli_rsp_t first;
        rsp = '0;
        if (stop_run) return;
        cli_req_valid = 1'b1;
        cli_req.op    = op;
        cli_req.addr  = addr;
        cli_req.wdata = wdata;
        waited = 0;
        while (!cli_req_ready && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!cli_req_ready) begin
            note_timeout("request was never accepted");
            return;
        end
        @(negedge clk);
        cli_req_valid = 1'b0;
        waited = 0;
        while (!cli_rsp_valid && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!cli_rsp_valid) begin
            note_timeout("no response arrived");
            return;
        end
        first = cli_rsp;
        repeat (hold) begin
            @(negedge clk);
            chk_cnt++;
            assert (cli_rsp_valid && cli_rsp === first && !cli_req_ready) else begin
                err_cnt++;
                $display("Response changed or request channel opened under back-pressure");
            end
        end
        cli_rsp_ready = 1'b1;
        rsp = cli_rsp;
        @(negedge clk);
        cli_rsp_ready = 1'b0;
    endtask

    // Model update, request and check of one operation
    task automatic run_op(input amo_pkg::amo_op_e op, input addr_t addr,
                          input amo_pkg::data_t wdata, input int unsigned hold,
                          input string name);
        amo_pkg::cli_rsp_t rsp;
        amo_pkg::data_t    old;
        amo_pkg::data_t    exp_data;
        logic              exp_err;
        int                idx;
        old      = model_mem[addr];
        exp_err  = 1'b0;
        exp_data = '0;
        if (op == amo_pkg::OP_LOAD) begin
            exp_data = old;
        end else if (op == amo_pkg::OP_STORE) begin
            model_mem[addr] = wdata;
        end else if (op <= amo_pkg::OP_AST_UMIN) begin
            idx = int'(op) - int'(amo_pkg::OP_ALD_SWAP);
            exp_data = (idx % 2 == 1) ? '0 : old;
            model_mem[addr] = alu_model(idx / 2, old, wdata);
        end else begin
            exp_data = '1;
            exp_err  = 1'b1;
        end
        send_request(op, addr, wdata, hold, rsp);
        check_word({name, " data"}, exp_data, rsp.rdata);
        check_word({name, " err"}, 32'(exp_err), 32'(rsp.err));
    endtask

    task automatic plain_access();
        addr_t          addrs [4] = '{8'd3, 8'd17, 8'd128, 8'd255};
        amo_pkg::data_t vals  [4] = '{32'h0000_0001, 32'hdead_beef, 32'h8000_0000,
                                      32'hffff_ffff};
        for (int i = 0; i < 4; i++) begin
            run_op(amo_pkg::OP_STORE, addrs[i], vals[i], 0, "plain store");
        end
        for (int i = 0; i < 4; i++) begin
            run_op(amo_pkg::OP_LOAD, addrs[i], '0, 0, "plain load");
        end
        // Word never written keeps its fill
        run_op(amo_pkg::OP_LOAD, 8'd64, '0, 0, "plain load of fill");
    endtask

    task automatic atomic_loads();
        amo_pkg::data_t olds [3] = '{32'h8000_0001, 32'hffff_ff00, 32'h0000_1234};
        amo_pkg::data_t opds [3] = '{32'h7fff_fffe, 32'h0000_00ff, 32'hfedc_ba98};
        addr_t          addr;
        for (int fn = 0; fn < 9; fn++) begin
            addr = addr_t'(16 + fn);
            for (int i = 0; i < 3; i++) begin
                run_op(amo_pkg::OP_STORE, addr, olds[i], 0, "atomic load setup");
                run_op(atomic_op(fn, 1'b0), addr, opds[i], 0,
                       $sformatf("atomic load fn %0d", fn));
                run_op(amo_pkg::OP_LOAD, addr, '0, 0, $sformatf("atomic load result fn %0d", fn));
            end
        end
    endtask

    task automatic atomic_stores();
        addr_t addr;
        for (int fn = 0; fn < 9; fn++) begin
            addr = addr_t'(32 + fn);
            run_op(amo_pkg::OP_STORE, addr, 32'hf00d_1234, 0, "atomic store setup");
            run_op(atomic_op(fn, 1'b1), addr, 32'h0ff0_8001, 0,
                   $sformatf("atomic store fn %0d", fn));
            run_op(amo_pkg::OP_LOAD, addr, '0, 0, $sformatf("atomic store result fn %0d", fn));
        end
    endtask

    task automatic undefined_opcode();
        run_op(amo_pkg::OP_STORE, 8'd42, 32'h1357_9bdf, 0, "undefined opcode setup");
        run_op(amo_pkg::amo_op_e'(5'd20), 8'd42, 32'h0000_0000, 0, "undefined opcode 20");
        run_op(amo_pkg::amo_op_e'(5'd31), 8'd42, 32'hffff_ffff, 0, "undefined opcode 31");
        run_op(amo_pkg::OP_LOAD, 8'd42, '0, 0, "undefined opcode untouched");
    endtask

    task automatic response_backpressure();
        amo_pkg::amo_op_e ops [4] = '{amo_pkg::OP_STORE, amo_pkg::OP_LOAD,
                                      amo_pkg::OP_ALD_ADD, amo_pkg::amo_op_e'(5'd25)};
        for (int i = 0; i < 4; i++) begin
            run_op(ops[i], 8'd50, 32'h7654_3210, 1 + $urandom % 8, "back-pressure");
        end
    endtask

    task automatic random_mix();
        int unsigned      sel;
        amo_pkg::amo_op_e op;
        amo_pkg::data_t   wdata;
        for (int i = 0; i < 200; i++) begin
            sel = $urandom % 24;
            if (sel >= 20) begin
                op = amo_pkg::amo_op_e'(5'(20 + $urandom % 12));
            end else begin
                op = amo_pkg::amo_op_e'(5'(sel));
            end
            // Sign boundary values now and then
            wdata = ($urandom % 4 == 0) ? 32'h8000_0000 : $urandom;
            run_op(op, addr_t'($urandom % 8), wdata, $urandom % 3, "random mix");
        end
    endtask

    initial begin
        void'($urandom(30));
        chk_cnt       = 0;
        err_cnt       = 0;
        stop_run      = 1'b0;
        clk           = 1'b0;
        rst_n         = 1'b0;
        cli_req_valid = 1'b0;
        cli_req       = '0;
        cli_rsp_ready = 1'b0;
        for (int a = 0; a < `AMO_MEM_WORDS; a++) begin
            model_mem[a] = fill_word(a);
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        plain_access();
        atomic_loads();
        atomic_stores();
        undefined_opcode();
        response_backpressure();
        random_mix();
        prot_cnt = amo_adapter_top_i.amo_checker_i.fail_cnt;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 chk_cnt, err_cnt, prot_cnt);
        if (err_cnt == 0 && prot_cnt == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- tests/amo_checker.sv
//****************************************************************************
// AMO adapter protocol checker
// Handshake stability and single-request rules on the top level ports
//****************************************************************************

`timescale 1ns/100ps

module amo_checker (
    input logic              clk_i,
    input logic              rst_ni,
    input logic              cli_req_valid_i,
    input logic              cli_req_ready_i,
    input logic              cli_rsp_valid_i,
    input logic              cli_rsp_ready_i,
    input amo_pkg::cli_rsp_t cli_rsp_i,
    input logic              mem_req_valid_i,
    input logic              mem_req_ready_i,
    input amo_pkg::mem_req_t mem_req_i
);

    int unsigned fail_cnt;
    // From request transfer until its response transfers
    logic        pending_q;

    initial begin
        fail_cnt = 0;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pending_q <= 1'b0;
        end else if (cli_req_valid_i && cli_req_ready_i) begin
            pending_q <= 1'b1;
        end else if (cli_rsp_valid_i && cli_rsp_ready_i) begin
            pending_q <= 1'b0;
        end
    end

    mem_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_valid_i && !mem_req_ready_i |=> mem_req_valid_i && $stable(mem_req_i))
        else begin
            fail_cnt++;
            $error("Memory request changed while stalled");
        end

    cli_rsp_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        cli_rsp_valid_i && !cli_rsp_ready_i |=> cli_rsp_valid_i && $stable(cli_rsp_i))
        else begin
            fail_cnt++;
            $error("Client response changed while stalled");
        end

    // One request in flight
    req_blocked: assert property (@(posedge clk_i) disable iff (!rst_ni)
        pending_q |-> !cli_req_ready_i)
        else begin
            fail_cnt++;
            $error("Request channel ready while a response is pending");
        end

endmodule

bind amo_adapter_top amo_checker amo_checker_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .cli_req_valid_i (cli_req_valid_i),
    .cli_req_ready_i (cli_req_ready_o),
    .cli_rsp_valid_i (cli_rsp_valid_o),
    .cli_rsp_ready_i (cli_rsp_ready_i),
    .cli_rsp_i       (cli_rsp_o),
    .mem_req_valid_i (mem_req_valid_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_req_i       (mem_req_o)
);

//--- tests/tb_memory.sv
//****************************************************************************
// Testbench word memory
// Stalls requests at random and answers each accepted one a cycle later
//****************************************************************************

`timescale 1ns/100ps

`include "amo_settings.svh"

module tb_memory (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              mem_req_valid_i,
    output logic              mem_req_ready_o,
    input  amo_pkg::mem_req_t mem_req_i,
    output logic              mem_rsp_valid_o,
    output amo_pkg::data_t    mem_rsp_rdata_o
);

    amo_pkg::data_t mem [`AMO_MEM_WORDS];
    logic           take_q;

    // Fill pattern spreads every address bit over the word
    initial begin
        for (int a = 0; a < `AMO_MEM_WORDS; a++) begin
            mem[a] = 32'h9e37_79b9 * (a + 1);
        end
    end

    // About one cycle in four is stalled
    always @(negedge clk_i) begin
        take_q <= ($urandom % 4) != 0;
    end

    assign mem_req_ready_o = rst_ni && take_q;

    always @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mem_rsp_valid_o <= 1'b0;
        end else begin
            mem_rsp_valid_o <= mem_req_valid_i && mem_req_ready_o;
            if (mem_req_valid_i && mem_req_ready_o) begin
                mem_rsp_rdata_o <= mem[mem_req_i.addr];
                if (mem_req_i.we) begin
                    mem[mem_req_i.addr] <= mem_req_i.wdata;
                end
            end
        end
    end

endmodule

//--- logic/amo_adapter_top.sv
//****************************************************************************
// AMO adapter top level
// Steering block and atomic engine share one memory port via the arbiter
//****************************************************************************

`timescale 1ns/100ps

`include "amo_settings.svh"

module amo_adapter_top (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              cli_req_valid_i,
    output logic              cli_req_ready_o,
    input  amo_pkg::cli_req_t cli_req_i,
    output logic              cli_rsp_valid_o,
    input  logic              cli_rsp_ready_i,
    output amo_pkg::cli_rsp_t cli_rsp_o,
    output logic              mem_req_valid_o,
    input  logic              mem_req_ready_i,
    output amo_pkg::mem_req_t mem_req_o,
    input  logic              mem_rsp_valid_i,
    input  amo_pkg::data_t    mem_rsp_rdata_i
);

    // Steering block on arbiter port 0
    logic                   s_req_valid;
    logic                   s_req_ready;
    amo_pkg::mem_req_t      s_req;
    logic                   s_rsp_valid;

    // Engine on arbiter port 1
    logic                   e_req_valid;
    logic                   e_req_ready;
    amo_pkg::mem_req_t      e_req;
    logic                   e_lock;
    logic                   e_rsp_valid;

    // Atomic hand-off between steering and engine
    logic                   amo_valid;
    logic                   amo_ready;
    amo_pkg::amo_fn_e       amo_fn;
    logic [`AMO_ADDR_W-1:0] amo_addr;
    amo_pkg::data_t         amo_operand;
    logic                   amo_done;
    amo_pkg::data_t         amo_old;

    amo_req_steer amo_req_steer_i (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .cli_req_valid_i (cli_req_valid_i),
        .cli_req_ready_o (cli_req_ready_o),
        .cli_req_i       (cli_req_i),
        .cli_rsp_valid_o (cli_rsp_valid_o),
        .cli_rsp_ready_i (cli_rsp_ready_i),
        .cli_rsp_o       (cli_rsp_o),
        .mem_req_valid_o (s_req_valid),
        .mem_req_ready_i (s_req_ready),
        .mem_req_o       (s_req),
        .mem_rsp_valid_i (s_rsp_valid),
        .mem_rsp_rdata_i (mem_rsp_rdata_i),
        .amo_valid_o     (amo_valid),
        .amo_ready_i     (amo_ready),
        .amo_fn_o        (amo_fn),
        .amo_addr_o      (amo_addr),
        .amo_operand_o   (amo_operand),
        .amo_done_i      (amo_done),
        .amo_old_i       (amo_old)
    );

    amo_engine amo_engine_i (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .start_valid_i   (amo_valid),
        .start_ready_o   (amo_ready),
        .fn_i            (amo_fn),
        .addr_i          (amo_addr),
        .operand_i       (amo_operand),
        .mem_req_valid_o (e_req_valid),
        .mem_req_ready_i (e_req_ready),
        .mem_req_o       (e_req),
        .lock_o          (e_lock),
        .mem_rsp_valid_i (e_rsp_valid),
        .mem_rsp_rdata_i (mem_rsp_rdata_i),
        .done_o          (amo_done),
        .old_o           (amo_old)
    );

    mem_arbiter mem_arbiter_i (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .req0_valid_i    (s_req_valid),
        .req0_ready_o    (s_req_ready),
        .req0_i          (s_req),
        .rsp0_valid_o    (s_rsp_valid),
        .req1_valid_i    (e_req_valid),
        .req1_ready_o    (e_req_ready),
        .req1_i          (e_req),
        .lock1_i         (e_lock),
        .rsp1_valid_o    (e_rsp_valid),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_ready_i (mem_req_ready_i),
        .mem_req_o       (mem_req_o),
        .mem_rsp_valid_i (mem_rsp_valid_i)
    );

endmodule

//--- logic/amo_req_steer.sv
//****************************************************************************
// Request steering
// Decodes client requests, sends plain ones to memory, atomics to the
// engine, and builds the client response
//****************************************************************************

`timescale 1ns/100ps

`include "amo_settings.svh"

module amo_req_steer (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   cli_req_valid_i,
    output logic                   cli_req_ready_o,
    input  amo_pkg::cli_req_t      cli_req_i,
    output logic                   cli_rsp_valid_o,
    input  logic                   cli_rsp_ready_i,
    output amo_pkg::cli_rsp_t      cli_rsp_o,
    output logic                   mem_req_valid_o,
    input  logic                   mem_req_ready_i,
    output amo_pkg::mem_req_t      mem_req_o,
    input  logic                   mem_rsp_valid_i,
    input  amo_pkg::data_t         mem_rsp_rdata_i,
    output logic                   amo_valid_o,
    input  logic                   amo_ready_i,
    output amo_pkg::amo_fn_e       amo_fn_o,
    output logic [`AMO_ADDR_W-1:0] amo_addr_o,
    output amo_pkg::data_t         amo_operand_o,
    input  logic                   amo_done_i,
    input  amo_pkg::data_t         amo_old_i
);

    typedef enum logic [2:0] {
        IDLE,
        PLAIN_REQ,
        PLAIN_WAIT,
        AMO_START,
        AMO_WAIT,
        RESPOND
    } state_e;

    state_e            state_q;
    state_e            state_d;
    amo_pkg::mem_req_t req_q;
    amo_pkg::amo_fn_e  fn_q;
    logic              store_q;
    amo_pkg::cli_rsp_t rsp_q;
    logic              accept;
    logic              is_plain;
    logic              is_amo;
    logic [4:0]        op_off;

    // Atomic code minus the first atomic gives function and store flag
    assign op_off   = cli_req_i.op - amo_pkg::OP_ALD_SWAP;
    assign is_plain = (cli_req_i.op == amo_pkg::OP_LOAD) ||
                      (cli_req_i.op == amo_pkg::OP_STORE);
    assign is_amo   = (cli_req_i.op >= amo_pkg::OP_ALD_SWAP) &&
                      (cli_req_i.op <= amo_pkg::OP_AST_UMIN);

    assign accept          = (state_q == IDLE) && cli_req_valid_i;
    assign cli_req_ready_o = (state_q == IDLE);
    assign cli_rsp_valid_o = (state_q == RESPOND);
    assign cli_rsp_o       = rsp_q;
    assign mem_req_valid_o = (state_q == PLAIN_REQ);
    assign mem_req_o       = req_q;
    assign amo_valid_o     = (state_q == AMO_START);
    assign amo_fn_o        = fn_q;
    assign amo_addr_o      = req_q.addr;
    assign amo_operand_o   = req_q.wdata;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (cli_req_valid_i) begin
                    if (is_plain) begin
                        state_d = PLAIN_REQ;
                    end else if (is_amo) begin
                        state_d = AMO_START;
                    end else begin
                        state_d = RESPOND;
                    end
                end
            end
            PLAIN_REQ:  if (mem_req_ready_i) state_d = PLAIN_WAIT;
            PLAIN_WAIT: if (mem_rsp_valid_i) state_d = RESPOND;
            AMO_START:  if (amo_ready_i) state_d = AMO_WAIT;
            AMO_WAIT:   if (amo_done_i) state_d = RESPOND;
            RESPOND:    if (cli_rsp_ready_i) state_d = IDLE;
            default:    state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            req_q.addr  <= cli_req_i.addr;
            req_q.we    <= (cli_req_i.op == amo_pkg::OP_STORE);
            req_q.wdata <= cli_req_i.wdata;
            fn_q        <= amo_pkg::amo_fn_e'(op_off[4:1]);
            store_q     <= op_off[0];
            // Error response by default, replaced when a valid one completes
            rsp_q.rdata <= '1;
            rsp_q.err   <= 1'b1;
        end
        if (state_q == PLAIN_WAIT && mem_rsp_valid_i) begin
            rsp_q.rdata <= req_q.we ? '0 : mem_rsp_rdata_i;
            rsp_q.err   <= 1'b0;
        end
        if (state_q == AMO_WAIT && amo_done_i) begin
            rsp_q.rdata <= store_q ? '0 : amo_old_i;
            rsp_q.err   <= 1'b0;
        end
    end

endmodule

//--- logic/mem_arbiter.sv
//****************************************************************************
// Memory arbiter
// Shares one memory port between two requesters, port 1 first, with lock
//****************************************************************************

`timescale 1ns/100ps

module mem_arbiter (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              req0_valid_i,
    output logic              req0_ready_o,
    input  amo_pkg::mem_req_t req0_i,
    output logic              rsp0_valid_o,
    input  logic              req1_valid_i,
    output logic              req1_ready_o,
    input  amo_pkg::mem_req_t req1_i,
    input  logic              lock1_i,
    output logic              rsp1_valid_o,
    output logic              mem_req_valid_o,
    input  logic              mem_req_ready_i,
    output amo_pkg::mem_req_t mem_req_o,
    input  logic              mem_rsp_valid_i
);

    logic grant0;
    logic grant1;
    // Set when the last accepted request came from port 1
    logic owner_q;

    assign grant1 = req1_valid_i;
    assign grant0 = req0_valid_i && !req1_valid_i && !lock1_i;

    assign mem_req_valid_o = grant0 || grant1;
    assign mem_req_o       = grant1 ? req1_i : req0_i;

    assign req1_ready_o = mem_req_ready_i;
    assign req0_ready_o = mem_req_ready_i && !req1_valid_i && !lock1_i;

    // Responses come back in order, one request is outstanding at a time
    assign rsp0_valid_o = mem_rsp_valid_i && !owner_q;
    assign rsp1_valid_o = mem_rsp_valid_i && owner_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            owner_q <= 1'b0;
        end else if (mem_req_valid_o && mem_req_ready_i) begin
            owner_q <= grant1;
        end
    end

endmodule

//--- logic/amo_engine.sv
//****************************************************************************
// AMO engine
// Runs the read, compute and write-back sequence of one atomic
//****************************************************************************

`timescale 1ns/100ps

`include "amo_settings.svh"

module amo_engine (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   start_valid_i,
    output logic                   start_ready_o,
    input  amo_pkg::amo_fn_e       fn_i,
    input  logic [`AMO_ADDR_W-1:0] addr_i,
    input  amo_pkg::data_t         operand_i,
    output logic                   mem_req_valid_o,
    input  logic                   mem_req_ready_i,
    output amo_pkg::mem_req_t      mem_req_o,
    output logic                   lock_o,
    input  logic                   mem_rsp_valid_i,
    input  amo_pkg::data_t         mem_rsp_rdata_i,
    output logic                   done_o,
    output amo_pkg::data_t         old_o
);

    typedef enum logic [2:0] {
        IDLE,
        READ_REQ,
        READ_WAIT,
        WRITE_REQ,
        WRITE_WAIT
    } state_e;

    state_e                 state_q;
    amo_pkg::amo_fn_e       fn_q;
    logic [`AMO_ADDR_W-1:0] addr_q;
    amo_pkg::data_t         operand_q;
    amo_pkg::data_t         old_q;
    amo_pkg::data_t         result;
    logic                   done_q;

    amo_alu amo_alu_i (
        .fn_i      (fn_q),
        .old_i     (old_q),
        .operand_i (operand_q),
        .result_o  (result)
    );

    assign start_ready_o   = (state_q == IDLE);
    assign mem_req_valid_o = (state_q == READ_REQ) || (state_q == WRITE_REQ);
    assign mem_req_o.addr  = addr_q;
    assign mem_req_o.we    = (state_q == WRITE_REQ);
    assign mem_req_o.wdata = result;

    // Port stays ours from the read until the write is taken
    assign lock_o = (state_q == READ_REQ) || (state_q == READ_WAIT) ||
                    (state_q == WRITE_REQ);

    assign done_o = done_q;
    assign old_o  = old_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                IDLE:       if (start_valid_i) state_q <= READ_REQ;
                READ_REQ:   if (mem_req_ready_i) state_q <= READ_WAIT;
                READ_WAIT:  if (mem_rsp_valid_i) state_q <= WRITE_REQ;
                WRITE_REQ:  if (mem_req_ready_i) state_q <= WRITE_WAIT;
                WRITE_WAIT: begin
                    if (mem_rsp_valid_i) begin
                        state_q <= IDLE;
                        done_q  <= 1'b1;
                    end
                end
                default:    state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && start_valid_i) begin
            fn_q      <= fn_i;
            addr_q    <= addr_i;
            operand_q <= operand_i;
        end
        if (state_q == READ_WAIT && mem_rsp_valid_i) begin
            old_q <= mem_rsp_rdata_i;
        end
    end

endmodule

//--- logic/amo_alu.sv
//****************************************************************************
// AMO ALU
// Computes the new memory word of an atomic from old word and operand
//****************************************************************************

`timescale 1ns/100ps

module amo_alu (
    input  amo_pkg::amo_fn_e fn_i,
    input  amo_pkg::data_t   old_i,
    input  amo_pkg::data_t   operand_i,
    output amo_pkg::data_t   result_o
);

    logic old_gt_s;
    logic old_gt_u;

    // Comparisons shared by max and min
    assign old_gt_s = $signed(old_i) > $signed(operand_i);
    assign old_gt_u = old_i > operand_i;

    always_comb begin
        case (fn_i)
            amo_pkg::FN_SWAP: result_o = operand_i;
            amo_pkg::FN_ADD:  result_o = old_i + operand_i;
            amo_pkg::FN_CLR:  result_o = old_i & ~operand_i;
            amo_pkg::FN_SET:  result_o = old_i | operand_i;
            amo_pkg::FN_EOR:  result_o = old_i ^ operand_i;
            amo_pkg::FN_SMAX: result_o = old_gt_s ? old_i : operand_i;
            amo_pkg::FN_SMIN: result_o = old_gt_s ? operand_i : old_i;
            amo_pkg::FN_UMAX: result_o = old_gt_u ? old_i : operand_i;
            amo_pkg::FN_UMIN: result_o = old_gt_u ? operand_i : old_i;
            // Unused codes leave memory as it was
            default:          result_o = old_i;
        endcase
    end

endmodule

//--- logic/amo_pkg.sv
//****************************************************************************
// AMO adapter package
// Opcode and ALU function encodings, client and memory request types
//****************************************************************************

package amo_pkg;

    `include "amo_settings.svh"

    // Atomics are paired: even code returns the old word, odd code does not
    typedef enum logic [4:0] {
        OP_LOAD     = 5'd0,
        OP_STORE    = 5'd1,
        OP_ALD_SWAP = 5'd2,
        OP_AST_SWAP = 5'd3,
        OP_ALD_ADD  = 5'd4,
        OP_AST_ADD  = 5'd5,
        OP_ALD_CLR  = 5'd6,
        OP_AST_CLR  = 5'd7,
        OP_ALD_SET  = 5'd8,
        OP_AST_SET  = 5'd9,
        OP_ALD_EOR  = 5'd10,
        OP_AST_EOR  = 5'd11,
        OP_ALD_SMAX = 5'd12,
        OP_AST_SMAX = 5'd13,
        OP_ALD_SMIN = 5'd14,
        OP_AST_SMIN = 5'd15,
        OP_ALD_UMAX = 5'd16,
        OP_AST_UMAX = 5'd17,
        OP_ALD_UMIN = 5'd18,
        OP_AST_UMIN = 5'd19
    } amo_op_e;

    // Same order as the atomic opcode pairs
    typedef enum logic [3:0] {
        FN_SWAP = 4'd0,
        FN_ADD  = 4'd1,
        FN_CLR  = 4'd2,
        FN_SET  = 4'd3,
        FN_EOR  = 4'd4,
        FN_SMAX = 4'd5,
        FN_SMIN = 4'd6,
        FN_UMAX = 4'd7,
        FN_UMIN = 4'd8
    } amo_fn_e;

    typedef logic [`AMO_DATA_W-1:0] data_t;

    typedef struct packed {
        amo_op_e                op;
        logic [`AMO_ADDR_W-1:0] addr;
        data_t                  wdata;
    } cli_req_t;

    typedef struct packed {
        data_t rdata;
        logic  err;
    } cli_rsp_t;

    typedef struct packed {
        logic [`AMO_ADDR_W-1:0] addr;
        logic                   we;
        data_t                  wdata;
    } mem_req_t;

endpackage

//--- logic/amo_settings.svh
//****************************************************************************
// AMO adapter settings
// Word address width, data width and memory depth
//****************************************************************************

`ifndef AMO_SETTINGS_SVH
`define AMO_SETTINGS_SVH

// Word address, not byte address
`define AMO_ADDR_W 8

`define AMO_DATA_W 32

// One word per address
`define AMO_MEM_WORDS (1 << `AMO_ADDR_W)

`endif
